/* source/soc_pkg.sv */
package soc_pkg;

	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int LED_W = 10;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// Top address nibble
	typedef enum logic [3:0] {
		REGION_RAM = 4'h2,
		REGION_BRIDGE = 4'h5
	} region_e;

	// Peripheral select nibble behind the bridge
	typedef enum logic [3:0] {
		DEV_TIMER = 4'h5,
		DEV_SYSREG = 4'h9
	} device_e;

	typedef enum logic [1:0] {
		MASTER_NONE = 2'd0,
		MASTER_IBUS = 2'd1,
		MASTER_DBUS = 2'd2,
		MASTER_DMA = 2'd3
	} master_e;

	typedef enum logic [3:0] {
		TIMER_COUNT = 4'd0,
		TIMER_COMPARE = 4'd1
	} timer_reg_e;

	typedef enum logic [3:0] {
		SYSREG_DEVICE_ID = 4'd0,
		SYSREG_RAM_SIZE = 4'd1,
		SYSREG_LEDS = 4'd2
	} sysreg_e;

endpackage

/* source/bus_if.sv */
interface bus_if import soc_pkg::*; ();

	logic request;
	logic rw;
	addr_t address;
	word_t wdata;
	word_t rdata;
	logic ready;
	master_e source;

	modport master (
		output request, rw, address, wdata, source,
		input rdata, ready
	);

	modport slave (
		input request, rw, address, wdata, source,
		output rdata, ready
	);

endinterface

/* source/timer.sv */
module timer import soc_pkg::*; (
	input logic clock,
	input logic i_rst,
	input logic i_request,
	input logic i_rw,
	input timer_reg_e i_index,
	input word_t i_wdata,
	output word_t o_rdata,
	output logic o_ready,
	output logic o_interrupt
);

	word_t count;
	word_t compare;
	logic access;

	assign access = i_request && !o_ready;

	always_ff @(posedge clock) begin
		if (i_rst) begin
			count <= '0;
			compare <= '1;
			o_ready <= 1'b0;
		end else begin
			count <= count + 1'b1;
			o_ready <= access;
			// Counter itself is read only
			if (access && i_rw && i_index == TIMER_COMPARE)
				compare <= i_wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (access) begin
			case (i_index)
				TIMER_COUNT: o_rdata <= count;
				TIMER_COMPARE: o_rdata <= compare;
				default: o_rdata <= '0;
			endcase
		end
	end

	// Level stays up until compare moves past the counter
	assign o_interrupt = count >= compare;

endmodule

/* source/system_registers.sv */
module system_registers import soc_pkg::*; #(
	parameter int RAM_BYTES = 4096,
	parameter int DEVICE_ID = 1
) (
	input logic clock,
	input logic i_rst,
	input logic i_request,
	input logic i_rw,
	input sysreg_e i_index,
	input word_t i_wdata,
	output word_t o_rdata,
	output logic o_ready,
	output logic [LED_W-1:0] o_leds
);

	logic access;

	assign access = i_request && !o_ready;

	always_ff @(posedge clock) begin
		if (i_rst) begin
			o_ready <= 1'b0;
			o_leds <= '0;
		end else begin
			o_ready <= access;
			if (access && i_rw && i_index == SYSREG_LEDS)
				o_leds <= i_wdata[LED_W-1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (access) begin
			case (i_index)
				SYSREG_DEVICE_ID: o_rdata <= word_t'(DEVICE_ID);
				SYSREG_RAM_SIZE: o_rdata <= word_t'(RAM_BYTES);
				SYSREG_LEDS: o_rdata <= word_t'(o_leds);
				default: o_rdata <= '0;
			endcase
		end
	end

endmodule

/* source/bus_arbiter.sv */
module bus_arbiter import soc_pkg::*; (
	input logic clock,
	input logic i_rst,

	input logic i_ibus_request,
	input addr_t i_ibus_address,
	output word_t o_ibus_rdata,
	output logic o_ibus_ready,

	input logic i_dbus_request,
	input logic i_dbus_rw,
	input addr_t i_dbus_address,
	input word_t i_dbus_wdata,
	output word_t o_dbus_rdata,
	output logic o_dbus_ready,

	input logic i_dma_request,
	input logic i_dma_rw,
	input addr_t i_dma_address,
	input word_t i_dma_wdata,
	output word_t o_dma_rdata,
	output logic o_dma_ready,

	bus_if.master bus
);

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_BUSY,
		ARB_RESPOND
	} arb_state_e;

	arb_state_e state;
	master_e grant;
	logic request_q;
	logic rw_q;
	addr_t address_q;
	word_t wdata_q;
	word_t rdata_q;
	logic ibus_ready_q;
	logic dbus_ready_q;
	logic dma_ready_q;

	always_ff @(posedge clock) begin
		if (i_rst) begin
			state <= ARB_IDLE;
			grant <= MASTER_NONE;
			request_q <= 1'b0;
			ibus_ready_q <= 1'b0;
			dbus_ready_q <= 1'b0;
			dma_ready_q <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					// Fixed priority, ibus first
					if (i_ibus_request) begin
						grant <= MASTER_IBUS;
						request_q <= 1'b1;
						state <= ARB_BUSY;
					end else if (i_dbus_request) begin
						grant <= MASTER_DBUS;
						request_q <= 1'b1;
						state <= ARB_BUSY;
					end else if (i_dma_request) begin
						grant <= MASTER_DMA;
						request_q <= 1'b1;
						state <= ARB_BUSY;
					end
				end
				ARB_BUSY: begin
					if (bus.ready) begin
						request_q <= 1'b0;
						ibus_ready_q <= grant == MASTER_IBUS;
						dbus_ready_q <= grant == MASTER_DBUS;
						dma_ready_q <= grant == MASTER_DMA;
						state <= ARB_RESPOND;
					end
				end
				default: begin
					// Master sees its ready pulse here
					ibus_ready_q <= 1'b0;
					dbus_ready_q <= 1'b0;
					dma_ready_q <= 1'b0;
					grant <= MASTER_NONE;
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// Latched transaction of the granted master
	always_ff @(posedge clock) begin
		if (state == ARB_IDLE) begin
			if (i_ibus_request) begin
				rw_q <= 1'b0;
				address_q <= i_ibus_address;
				wdata_q <= '0;
			end else if (i_dbus_request) begin
				rw_q <= i_dbus_rw;
				address_q <= i_dbus_address;
				wdata_q <= i_dbus_wdata;
			end else begin
				rw_q <= i_dma_rw;
				address_q <= i_dma_address;
				wdata_q <= i_dma_wdata;
			end
		end
		if (state == ARB_BUSY && bus.ready)
			rdata_q <= bus.rdata;
	end

	assign bus.request = request_q;
	assign bus.rw = rw_q;
	assign bus.address = address_q;
	assign bus.wdata = wdata_q;
	assign bus.source = grant;

	assign o_ibus_rdata = rdata_q;
	assign o_dbus_rdata = rdata_q;
	assign o_dma_rdata = rdata_q;
	assign o_ibus_ready = ibus_ready_q;
	assign o_dbus_ready = dbus_ready_q;
	assign o_dma_ready = dma_ready_q;

	// A master only gets ready for the request it is still holding
	assert property (@(posedge clock) disable iff (i_rst) o_ibus_ready |-> i_ibus_request);
	assert property (@(posedge clock) disable iff (i_rst) o_dbus_ready |-> i_dbus_request);
	assert property (@(posedge clock) disable iff (i_rst) o_dma_ready |-> i_dma_request);

endmodule

/* source/bus_decoder.sv */
module bus_decoder import soc_pkg::*; (
	input logic clock,
	input logic i_rst,

	bus_if.slave cpu,
	bus_if.master ram,
	bus_if.master bridge,

	output logic o_bus_fault,
	output addr_t o_bus_fault_address,
	output master_e o_bus_fault_source
);

	region_e region;
	logic ram_select;
	logic bridge_select;
	logic fault_select;
	logic fault_ready;

	assign region = region_e'(cpu.address[31:28]);
	assign ram_select = region == REGION_RAM;
	assign bridge_select = region == REGION_BRIDGE;
	assign fault_select = !ram_select && !bridge_select;

	// ====================
	// Downstream requests, region nibble removed
	assign ram.request = cpu.request && ram_select;
	assign ram.rw = cpu.rw;
	assign ram.address = {4'h0, cpu.address[27:0]};
	assign ram.wdata = cpu.wdata;
	assign ram.source = cpu.source;

	assign bridge.request = cpu.request && bridge_select;
	assign bridge.rw = cpu.rw;
	assign bridge.address = {4'h0, cpu.address[27:0]};
	assign bridge.wdata = cpu.wdata;
	assign bridge.source = cpu.source;

	// ====================
	// Response mux
	assign cpu.rdata =
		ram_select ? ram.rdata :
		bridge_select ? bridge.rdata :
		'0;

	assign cpu.ready =
		ram_select ? ram.ready :
		bridge_select ? bridge.ready :
		fault_ready;

	// Unmapped regions close in one cycle so no master hangs
	always_ff @(posedge clock) begin
		if (i_rst)
			fault_ready <= 1'b0;
		else
			fault_ready <= cpu.request && fault_select && !fault_ready;
	end

	always_ff @(posedge clock) begin
		if (cpu.request && fault_select && !fault_ready) begin
			o_bus_fault_address <= cpu.address;
			o_bus_fault_source <= cpu.source;
		end
	end

	assign o_bus_fault = fault_ready;

endmodule

/* source/buffered_ram.sv */
module buffered_ram import soc_pkg::*; #(
	parameter int RAM_BYTES = 4096,
	parameter int WB_DEPTH = 4
) (
	input logic clock,
	input logic i_rst,
	bus_if.slave bus
);

	localparam int WORDS = RAM_BYTES / 4;
	localparam int IDX_W = $clog2(WORDS);
	localparam int PTR_W = (WB_DEPTH > 1) ? $clog2(WB_DEPTH) : 1;
	localparam int CNT_W = $clog2(WB_DEPTH + 1);

	word_t mem [WORDS];
	logic [IDX_W-1:0] fifo_index [WB_DEPTH];
	word_t fifo_data [WB_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [IDX_W-1:0] index;
	logic full;
	logic empty;
	logic push;
	logic pop;
	logic read_go;
	logic ready_q;
	word_t rdata_q;

	// Word index wraps at the RAM size
	assign index = bus.address[2 +: IDX_W];
	assign full = count == CNT_W'(WB_DEPTH);
	assign empty = count == '0;

	assign push = bus.request && bus.rw && !full && !ready_q;
	assign pop = !empty;
	// Reads wait for the buffer to drain
	assign read_go = bus.request && !bus.rw && empty && !ready_q;

	// ====================
	// Write buffer control
	always_ff @(posedge clock) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			ready_q <= 1'b0;
		end else begin
			ready_q <= push || read_go;
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(WB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(WB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			fifo_index[wr_ptr] <= index;
			fifo_data[wr_ptr] <= bus.wdata;
		end
	end

	// One entry drains per cycle
	always_ff @(posedge clock) begin
		if (pop)
			mem[fifo_index[rd_ptr]] <= fifo_data[rd_ptr];
		if (read_go)
			rdata_q <= mem[index];
	end

	assign bus.ready = ready_q;
	assign bus.rdata = rdata_q;

	// Write acknowledge implies there was room the cycle before
	assert property (@(posedge clock) disable iff (i_rst)
		bus.ready && bus.rw |-> $past(count) < CNT_W'(WB_DEPTH));

endmodule

/* source/periph_bridge.sv */
module periph_bridge import soc_pkg::*; #(
	parameter int RAM_BYTES = 4096,
	parameter int DEVICE_ID = 1
) (
	input logic clock,
	input logic i_rst,
	bus_if.slave bus,
	output logic [LED_W-1:0] o_leds,
	output logic o_timer_interrupt
);

	typedef enum logic [1:0] {
		BRIDGE_IDLE,
		BRIDGE_FAR,
		BRIDGE_RESPOND
	} bridge_state_e;

	bridge_state_e state;
	logic far_request;
	logic far_rw;
	device_e far_device;
	logic [3:0] far_index;
	word_t far_wdata;
	word_t far_rdata;
	logic far_ready;
	word_t rdata_q;

	logic timer_strobe;
	word_t timer_rdata;
	logic timer_ready;
	logic sysreg_strobe;
	word_t sysreg_rdata;
	logic sysreg_ready;
	logic none_strobe;
	logic none_ready;

	// ====================
	// Near side
	always_ff @(posedge clock) begin
		if (i_rst) begin
			state <= BRIDGE_IDLE;
		end else begin
			case (state)
				BRIDGE_IDLE:
					if (bus.request)
						state <= BRIDGE_FAR;
				BRIDGE_FAR:
					if (far_ready)
						state <= BRIDGE_RESPOND;
				default:
					state <= BRIDGE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == BRIDGE_IDLE && bus.request) begin
			far_rw <= bus.rw;
			far_device <= device_e'(bus.address[27:24]);
			far_index <= bus.address[5:2];
			far_wdata <= bus.wdata;
		end
		if (state == BRIDGE_FAR && far_ready)
			rdata_q <= far_rdata;
	end

	assign far_request = state == BRIDGE_FAR;
	assign bus.ready = state == BRIDGE_RESPOND;
	assign bus.rdata = rdata_q;

	// ====================
	// Far side decode
	assign timer_strobe = far_request && far_device == DEV_TIMER;
	assign sysreg_strobe = far_request && far_device == DEV_SYSREG;
	assign none_strobe = far_request && !(far_device inside {DEV_TIMER, DEV_SYSREG});

	// Unmapped device still answers a cycle later
	always_ff @(posedge clock) begin
		if (i_rst)
			none_ready <= 1'b0;
		else
			none_ready <= none_strobe && !none_ready;
	end

	timer timer_i (
		.clock(clock),
		.i_rst(i_rst),
		.i_request(timer_strobe),
		.i_rw(far_rw),
		.i_index(timer_reg_e'(far_index)),
		.i_wdata(far_wdata),
		.o_rdata(timer_rdata),
		.o_ready(timer_ready),
		.o_interrupt(o_timer_interrupt)
	);

	system_registers #(
		.RAM_BYTES(RAM_BYTES),
		.DEVICE_ID(DEVICE_ID)
	) system_registers_i (
		.clock(clock),
		.i_rst(i_rst),
		.i_request(sysreg_strobe),
		.i_rw(far_rw),
		.i_index(sysreg_e'(far_index)),
		.i_wdata(far_wdata),
		.o_rdata(sysreg_rdata),
		.o_ready(sysreg_ready),
		.o_leds(o_leds)
	);

	assign far_rdata =
		timer_strobe ? timer_rdata :
		sysreg_strobe ? sysreg_rdata :
		'0;
	assign far_ready = timer_ready || sysreg_ready || none_ready;

	// Devices answer only to a strobe of the previous cycle
	assert property (@(posedge clock) disable iff (i_rst) timer_ready |-> $past(timer_strobe));
	assert property (@(posedge clock) disable iff (i_rst) sysreg_ready |-> $past(sysreg_strobe));

endmodule

/* source/soc_fabric.sv */
module soc_fabric import soc_pkg::*; #(
	parameter int RAM_BYTES = 4096,
	parameter int WB_DEPTH = 4,
	parameter int DEVICE_ID = 1
) (
	input logic clock,
	input logic i_rst,

	// Instruction port, read only
	input logic i_ibus_request,
	input addr_t i_ibus_address,
	output word_t o_ibus_rdata,
	output logic o_ibus_ready,

	input logic i_dbus_request,
	input logic i_dbus_rw,
	input addr_t i_dbus_address,
	input word_t i_dbus_wdata,
	output word_t o_dbus_rdata,
	output logic o_dbus_ready,

	input logic i_dma_request,
	input logic i_dma_rw,
	input addr_t i_dma_address,
	input word_t i_dma_wdata,
	output word_t o_dma_rdata,
	output logic o_dma_ready,

	output logic [LED_W-1:0] o_leds,
	output logic o_timer_interrupt,
	output logic o_bus_fault,
	output addr_t o_bus_fault_address,
	output master_e o_bus_fault_source
);

	bus_if sys_bus ();
	bus_if ram_bus ();
	bus_if bridge_bus ();

	bus_arbiter bus_arbiter_i (
		.clock(clock),
		.i_rst(i_rst),
		.i_ibus_request(i_ibus_request),
		.i_ibus_address(i_ibus_address),
		.o_ibus_rdata(o_ibus_rdata),
		.o_ibus_ready(o_ibus_ready),
		.i_dbus_request(i_dbus_request),
		.i_dbus_rw(i_dbus_rw),
		.i_dbus_address(i_dbus_address),
		.i_dbus_wdata(i_dbus_wdata),
		.o_dbus_rdata(o_dbus_rdata),
		.o_dbus_ready(o_dbus_ready),
		.i_dma_request(i_dma_request),
		.i_dma_rw(i_dma_rw),
		.i_dma_address(i_dma_address),
		.i_dma_wdata(i_dma_wdata),
		.o_dma_rdata(o_dma_rdata),
		.o_dma_ready(o_dma_ready),
		.bus(sys_bus.master)
	);

	bus_decoder bus_decoder_i (
		.clock(clock),
		.i_rst(i_rst),
		.cpu(sys_bus.slave),
		.ram(ram_bus.master),
		.bridge(bridge_bus.master),
		.o_bus_fault(o_bus_fault),
		.o_bus_fault_address(o_bus_fault_address),
		.o_bus_fault_source(o_bus_fault_source)
	);

	buffered_ram #(
		.RAM_BYTES(RAM_BYTES),
		.WB_DEPTH(WB_DEPTH)
	) buffered_ram_i (
		.clock(clock),
		.i_rst(i_rst),
		.bus(ram_bus.slave)
	);

	periph_bridge #(
		.RAM_BYTES(RAM_BYTES),
		.DEVICE_ID(DEVICE_ID)
	) periph_bridge_i (
		.clock(clock),
		.i_rst(i_rst),
		.bus(bridge_bus.slave),
		.o_leds(o_leds),
		.o_timer_interrupt(o_timer_interrupt)
	);

endmodule

/* sim/tb_soc_fabric.sv */
module tb_soc_fabric import soc_pkg::*; ();

	localparam int RAM_BYTES = 4096;
	localparam int WB_DEPTH = 4;
	localparam int DEVICE_ID = 1;
	localparam int DRIVE_DELAY = 10;
	localparam int WAIT_LIMIT = 200;
	localparam int HALF_WORDS = RAM_BYTES / 8;

	logic clock;
	logic i_rst;
	logic i_ibus_request;
	addr_t i_ibus_address;
	word_t o_ibus_rdata;
	logic o_ibus_ready;
	logic i_dbus_request;
	logic i_dbus_rw;
	addr_t i_dbus_address;
	word_t i_dbus_wdata;
	word_t o_dbus_rdata;
	logic o_dbus_ready;
	logic i_dma_request;
	logic i_dma_rw;
	addr_t i_dma_address;
	word_t i_dma_wdata;
	word_t o_dma_rdata;
	logic o_dma_ready;
	logic [LED_W-1:0] o_leds;
	logic o_timer_interrupt;
	logic o_bus_fault;
	addr_t o_bus_fault_address;
	master_e o_bus_fault_source;

	// Reference model
	word_t ram_model [int];
	int written_words [$];
	logic [LED_W-1:0] led_model;

	// Fault pulses seen mid cycle
	int fault_count;
	addr_t fault_address_seen;
	master_e fault_source_seen;

	soc_fabric #(
		.RAM_BYTES(RAM_BYTES),
		.WB_DEPTH(WB_DEPTH),
		.DEVICE_ID(DEVICE_ID)
	) soc_fabric_i (
		.clock(clock),
		.i_rst(i_rst),
		.i_ibus_request(i_ibus_request),
		.i_ibus_address(i_ibus_address),
		.o_ibus_rdata(o_ibus_rdata),
		.o_ibus_ready(o_ibus_ready),
		.i_dbus_request(i_dbus_request),
		.i_dbus_rw(i_dbus_rw),
		.i_dbus_address(i_dbus_address),
		.i_dbus_wdata(i_dbus_wdata),
		.o_dbus_rdata(o_dbus_rdata),
		.o_dbus_ready(o_dbus_ready),
		.i_dma_request(i_dma_request),
		.i_dma_rw(i_dma_rw),
		.i_dma_address(i_dma_address),
		.i_dma_wdata(i_dma_wdata),
		.o_dma_rdata(o_dma_rdata),
		.o_dma_ready(o_dma_ready),
		.o_leds(o_leds),
		.o_timer_interrupt(o_timer_interrupt),
		.o_bus_fault(o_bus_fault),
		.o_bus_fault_address(o_bus_fault_address),
		.o_bus_fault_source(o_bus_fault_source)
	);

	always #50 clock = ~clock;

	always @(negedge clock) begin
		if (o_bus_fault === 1'b1) begin
			fault_count++;
			fault_address_seen = o_bus_fault_address;
			fault_source_seen = o_bus_fault_source;
		end
	end

	// ====================
	// Failure reporting and compare tasks
	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped after an error");
	endtask

	task automatic check_word(input string test, input word_t expected, input word_t actual);
		if (actual !== expected)
			stop_with_failure($sformatf("FAIL %s expected %h actual %h", test, expected, actual));
	endtask

	task automatic check_leds(input string test, input logic [LED_W-1:0] expected,
		input logic [LED_W-1:0] actual);
		if (actual !== expected)
			stop_with_failure($sformatf("FAIL %s expected %h actual %h", test, expected, actual));
	endtask

	task automatic check_source(input string test, input master_e expected, input master_e actual);
		if (actual !== expected)
			stop_with_failure($sformatf("FAIL %s expected %0d actual %0d", test, expected, actual));
	endtask

	task automatic check_address(input string test, input addr_t expected, input addr_t actual);
		if (actual !== expected)
			stop_with_failure($sformatf("FAIL %s expected %h actual %h", test, expected, actual));
	endtask

	function automatic addr_t ram_address(input int word_index);
		return {4'(REGION_RAM), 28'(word_index * 4)};
	endfunction

	function automatic addr_t periph_address(input device_e device, input int index);
		return {4'(REGION_BRIDGE), 4'(device), 18'h0, 4'(index), 2'b00};
	endfunction

	task automatic idle_cycles(input int cycles);
		repeat (cycles) @(posedge clock);
		#DRIVE_DELAY;
	endtask

	// ====================
	// Master drivers, entered and left just after a rising edge
	task automatic ibus_read(input addr_t address, output word_t rdata);
		int cycles;
		i_ibus_request = 1'b1;
		i_ibus_address = address;
		cycles = 0;
		do begin
			@(posedge clock);
			#DRIVE_DELAY;
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_with_failure("ibus read got no ready before the timeout");
		end while (o_ibus_ready !== 1'b1);
		rdata = o_ibus_rdata;
		// Request stays up through the ready cycle
		@(posedge clock);
		#DRIVE_DELAY;
		i_ibus_request = 1'b0;
		if (o_ibus_ready !== 1'b0)
			stop_with_failure("ibus ready stayed high for more than one cycle");
	endtask

	task automatic dbus_access(input logic rw, input addr_t address, input word_t wdata,
		output word_t rdata);
		int cycles;
		i_dbus_request = 1'b1;
		i_dbus_rw = rw;
		i_dbus_address = address;
		i_dbus_wdata = wdata;
		cycles = 0;
		do begin
			@(posedge clock);
			#DRIVE_DELAY;
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_with_failure("dbus transaction got no ready before the timeout");
		end while (o_dbus_ready !== 1'b1);
		rdata = o_dbus_rdata;
		@(posedge clock);
		#DRIVE_DELAY;
		i_dbus_request = 1'b0;
	endtask

	task automatic dma_access(input logic rw, input addr_t address, input word_t wdata,
		output word_t rdata);
		int cycles;
		i_dma_request = 1'b1;
		i_dma_rw = rw;
		i_dma_address = address;
		i_dma_wdata = wdata;
		cycles = 0;
		do begin
			@(posedge clock);
			#DRIVE_DELAY;
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_with_failure("dma transaction got no ready before the timeout");
		end while (o_dma_ready !== 1'b1);
		rdata = o_dma_rdata;
		@(posedge clock);
		#DRIVE_DELAY;
		i_dma_request = 1'b0;
	endtask

	task automatic master_access(input master_e who, input logic rw, input addr_t address,
		input word_t wdata, output word_t rdata);
		if (who == MASTER_IBUS)
			ibus_read(address, rdata);
		else if (who == MASTER_DMA)
			dma_access(rw, address, wdata, rdata);
		else
			dbus_access(rw, address, wdata, rdata);
	endtask

	// Random writes and reads inside one half of the RAM
	task automatic run_ram_traffic(input master_e who, input int base_word, input int ops);
		int own_words [$];
		int word_index;
		word_t data;
		word_t seen;
		string test;
		test = (who == MASTER_DMA) ? "dma_ram_read" : "dbus_ram_read";
		for (int n = 0; n < ops; n++) begin
			if (own_words.size() == 0 || $urandom_range(1) == 0) begin
				word_index = base_word + $urandom_range(HALF_WORDS - 1);
				data = $urandom;
				master_access(who, 1'b1, ram_address(word_index), data, seen);
				if (!ram_model.exists(word_index)) begin
					own_words.push_back(word_index);
					written_words.push_back(word_index);
				end
				ram_model[word_index] = data;
			end else begin
				word_index = own_words[$urandom_range(own_words.size() - 1)];
				master_access(who, 1'b0, ram_address(word_index), '0, seen);
				check_word(test, ram_model[word_index], seen);
			end
			// Idle gap lets the lower priority master in
			idle_cycles($urandom_range(3, 1));
		end
	endtask

	task automatic wait_interrupt(input logic level);
		int cycles;
		cycles = 0;
		while (o_timer_interrupt !== level) begin
			@(posedge clock);
			#DRIVE_DELAY;
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_with_failure($sformatf("timer interrupt did not go to %0b in time", level));
		end
	endtask

	// ====================
	initial begin
		word_t seen;
		word_t first;
		word_t data;
		int word_index;
		master_e who;
		addr_t address;
		logic [3:0] region;
		void'($urandom(93606));
		clock = 1'b0;
		i_rst = 1'b1;
		i_ibus_request = 1'b0;
		i_ibus_address = '0;
		i_dbus_request = 1'b0;
		i_dbus_rw = 1'b0;
		i_dbus_address = '0;
		i_dbus_wdata = '0;
		i_dma_request = 1'b0;
		i_dma_rw = 1'b0;
		i_dma_address = '0;
		i_dma_wdata = '0;
		fault_count = 0;
		led_model = '0;
		repeat (16) @(posedge clock);
		#DRIVE_DELAY;
		i_rst = 1'b0;
		if (o_timer_interrupt !== 1'b0)
			stop_with_failure("timer interrupt is not low after reset");
		check_leds("leds_after_reset", led_model, o_leds);

		// RAM under contention, each master in its own half
		fork
			run_ram_traffic(MASTER_DBUS, 0, 60);
			run_ram_traffic(MASTER_DMA, HALF_WORDS, 60);
		join
		if (fault_count != 0)
			stop_with_failure("bus fault raised during RAM traffic");

		// Instruction port reads back written words
		for (int n = 0; n < 40; n++) begin
			word_index = written_words[$urandom_range(written_words.size() - 1)];
			ibus_read(ram_address(word_index), seen);
			check_word("ibus_ram_read", ram_model[word_index], seen);
		end

		// System registers
		dbus_access(1'b0, periph_address(DEV_SYSREG, SYSREG_DEVICE_ID), '0, seen);
		check_word("device_id", word_t'(DEVICE_ID), seen);
		dbus_access(1'b0, periph_address(DEV_SYSREG, SYSREG_RAM_SIZE), '0, seen);
		check_word("ram_size", word_t'(RAM_BYTES), seen);
		data = $urandom;
		led_model = data[LED_W-1:0];
		dbus_access(1'b1, periph_address(DEV_SYSREG, SYSREG_LEDS), data, seen);
		check_leds("led_output", led_model, o_leds);
		dma_access(1'b0, periph_address(DEV_SYSREG, SYSREG_LEDS), '0, seen);
		check_word("led_readback", word_t'(led_model), seen);

		// Timer
		dbus_access(1'b0, periph_address(DEV_TIMER, TIMER_COUNT), '0, first);
		dbus_access(1'b0, periph_address(DEV_TIMER, TIMER_COUNT), '0, seen);
		if (!(seen > first))
			stop_with_failure($sformatf("FAIL timer_count expected above %h actual %h",
				first, seen));
		dbus_access(1'b1, periph_address(DEV_TIMER, TIMER_COMPARE), '0, seen);
		wait_interrupt(1'b1);
		dbus_access(1'b1, periph_address(DEV_TIMER, TIMER_COMPARE), '1, seen);
		wait_interrupt(1'b0);

		// Unmapped regions
		for (int n = 0; n < 8; n++) begin
			do
				region = 4'($urandom_range(15));
			while (region == REGION_RAM || region == REGION_BRIDGE);
			address = {region, 28'($urandom)};
			who = master_e'($urandom_range(3, 1));
			fault_count = 0;
			master_access(who, 1'b0, address, '0, seen);
			check_word("fault_rdata", '0, seen);
			if (fault_count != 1)
				stop_with_failure($sformatf("bus fault pulsed %0d times for one request",
					fault_count));
			check_address("fault_address", address, fault_address_seen);
			check_source("fault_source", who, fault_source_seen);
		end

		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* soc_fabric.f */
source/soc_pkg.sv
source/bus_if.sv
source/timer.sv
source/system_registers.sv
source/bus_arbiter.sv
source/bus_decoder.sv
source/buffered_ram.sv
source/periph_bridge.sv
source/soc_fabric.sv
sim/tb_soc_fabric.sv
